// File: verilog/l2_cache_defs.svh
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Address split: tag | set | offset
//////////////////////////////////////////////////////////////////////
`define L2_ADDR_BITS   16
`define L2_OFFSET_BITS 4   // Byte within line
`define L2_SET_BITS    3
`define L2_TAG_BITS    9

`define L2_SETS        (1 << `L2_SET_BITS)

// Line and associativity
`define L2_LINE_BITS   128
`define L2_WAYS        8   // PLRU tree assumes exactly 8

`endif

// File: verilog/l2_cache_pkg.sv
`include "l2_cache_defs.svh"

package l2_cache_pkg;

    typedef logic [`L2_ADDR_BITS-1:0] l2_word_t;
    typedef logic [`L2_LINE_BITS-1:0] l2_line_t;

    typedef struct packed {
        logic [`L2_TAG_BITS-1:0]    tag;
        logic [`L2_SET_BITS-1:0]    set;
        logic [`L2_OFFSET_BITS-1:0] offset;
    } l2_addr_t;

    // Per-way lookup result for the current set
    typedef struct packed {
        logic hit;
        logic v_out;
        logic d_out;
    } l2_way_status_t;

    typedef l2_way_status_t [`L2_WAYS-1:0] l2_way_status_arr_t;

    typedef struct packed {
        logic load_v;
        logic v_in;
        logic load_d;
        logic d_in;
        logic load_td;   // Tag and line together
    } l2_way_ctl_t;

    typedef struct packed {
        l2_way_ctl_t [`L2_WAYS-1:0] way;
        logic                       load_lru;
    } l2_ctl_t;

    typedef enum logic [1:0] {
        ST_PROCESS,
        ST_EVICT,
        ST_WRITE_BACK,
        ST_FETCH
    } l2_state_e;

    typedef enum logic {
        SEL_REQUEST,
        SEL_VICTIM
    } l2_addr_sel_e;

endpackage

// File: verilog/l2_cache_way.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_way (
    input  logic                          clk,
    input  logic                          reset,
    input  l2_cache_pkg::l2_addr_t        addr,
    input  l2_cache_pkg::l2_line_t        wdata,
    input  l2_cache_pkg::l2_way_ctl_t     ctl,
    output l2_cache_pkg::l2_way_status_t  status,
    output logic [`L2_TAG_BITS-1:0]       tag,
    output l2_cache_pkg::l2_line_t        rdata
);
    import l2_cache_pkg::*;

    logic [`L2_TAG_BITS-1:0] tag_mem [`L2_SETS];
    l2_line_t                data_mem [`L2_SETS];
    logic [`L2_SETS-1:0]     valid;
    logic [`L2_SETS-1:0]     dirty;

    //////////////////////////////////////////////////////////////////////
    // Status bits
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (ctl.load_v)
                valid[addr.set] <= ctl.v_in;
            if (ctl.load_d)
                dirty[addr.set] <= ctl.d_in;
        end
    end

    // Tag and line arrays
    always_ff @(posedge clk) begin
        if (ctl.load_td) begin
            tag_mem[addr.set]  <= addr.tag;
            data_mem[addr.set] <= wdata;
        end
    end

    // Combinational read so a hit answers in the same cycle
    assign tag   = tag_mem[addr.set];
    assign rdata = data_mem[addr.set];

    assign status.v_out = valid[addr.set];
    assign status.d_out = dirty[addr.set];
    assign status.hit   = valid[addr.set] && (tag_mem[addr.set] == addr.tag);

endmodule

// File: verilog/l2_plru.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_plru (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`L2_SET_BITS-1:0] set,
    input  logic                    load_lru,
    input  logic [2:0]              hit_way,
    output logic [2:0]              victim_way
);

    // Bit 0 root, bits 1-2 quad level, bits 3-6 pair level
    logic [`L2_SETS-1:0][6:0] lru_bits;
    logic [6:0]               cur;
    logic [6:0]               next_bits;

    assign cur = lru_bits[set];

    // Walk the tree toward the pointed half each level
    assign victim_way[2] = cur[0];
    assign victim_way[1] = cur[0] ? cur[2] : cur[1];
    assign victim_way[0] = cur[3 + victim_way[2:1]];

    always_comb begin
        next_bits    = cur;
        next_bits[0] = ~hit_way[2];          // Point away from accessed way
        if (hit_way[2])
            next_bits[2] = ~hit_way[1];
        else
            next_bits[1] = ~hit_way[1];
        next_bits[3 + hit_way[2:1]] = ~hit_way[0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (load_lru) begin
            lru_bits[set] <= next_bits;
        end
    end

endmodule

// File: verilog/l2_cache_control.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_control (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  l2_cache_pkg::l2_way_status_arr_t  way_status,
    input  logic [2:0]                        victim_way,
    input  logic                              pmem_resp,
    output l2_cache_pkg::l2_ctl_t             ctl,
    output l2_cache_pkg::l2_addr_sel_e        addr_sel,
    output logic [2:0]                        victim_sel,
    output logic                              mem_resp,
    output logic                              pmem_read,
    output logic                              pmem_write,
    output logic                              eviction,
    output logic                              l2hits_inc,
    output logic                              l2misses_inc
);
    import l2_cache_pkg::*;

    l2_state_e            state;
    l2_state_e            next_state;
    logic                 request;
    logic                 hit;
    logic [2:0]           hit_way;
    logic [`L2_WAYS-1:0]  hit_vec;
    logic                 victim_dirty;
    logic                 victim_valid;

    assign request = mem_read ^ mem_write;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `L2_WAYS; i++) begin
            hit_vec[i] = way_status[i].hit;
            if (way_status[i].hit) begin
                hit     = 1'b1;
                hit_way = 3'(i);
            end
        end
    end

    assign victim_dirty = way_status[victim_way].d_out;
    assign victim_valid = way_status[victim_way].v_out;

    // Hit way for the PLRU update, else the victim
    assign victim_sel = hit ? hit_way : victim_way;

    //////////////////////////////////////////////////////////////////////
    // State register and next state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_PROCESS;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_PROCESS: begin
                if (request && !hit) begin
                    if (victim_dirty)
                        next_state = ST_WRITE_BACK;
                    else if (victim_valid)
                        next_state = ST_EVICT;
                    else
                        next_state = ST_FETCH;
                end
            end
            ST_EVICT:      next_state = ST_FETCH;   // Victim cache takes it in one cycle
            ST_WRITE_BACK: if (pmem_resp) next_state = ST_FETCH;
            ST_FETCH:      if (pmem_resp) next_state = ST_PROCESS;
            default:       next_state = ST_PROCESS;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctl          = '0;
        addr_sel     = SEL_REQUEST;
        mem_resp     = 1'b0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        eviction     = 1'b0;
        l2hits_inc   = 1'b0;
        l2misses_inc = 1'b0;
        case (state)
            ST_PROCESS: begin
                if (request && hit) begin
                    mem_resp     = 1'b1;
                    l2hits_inc   = 1'b1;
                    ctl.load_lru = 1'b1;
                    if (mem_write) begin
                        ctl.way[hit_way].load_d  = 1'b1;
                        ctl.way[hit_way].d_in    = 1'b1;
                        ctl.way[hit_way].load_td = 1'b1;
                    end
                end else if (request) begin
                    l2misses_inc = 1'b1;
                    // Address register lags a cycle so pick the victim now
                    if (victim_valid)
                        addr_sel = SEL_VICTIM;
                end
            end
            ST_EVICT: begin
                eviction = 1'b1;
            end
            ST_WRITE_BACK: begin
                pmem_write = 1'b1;
                if (!pmem_resp)
                    addr_sel = SEL_VICTIM;
            end
            ST_FETCH: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctl.way[victim_way].load_v  = 1'b1;
                    ctl.way[victim_way].v_in    = 1'b1;
                    ctl.way[victim_way].load_d  = 1'b1;   // Fresh line is clean
                    ctl.way[victim_way].load_td = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Memory side never sees both commands
    assert property (@(posedge clk) disable iff (reset) !(pmem_read && pmem_write));

    // Tags within a set stay unique across the ways
    assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec));

    // Refilled line hits on the held request
    assert property (@(posedge clk) disable iff (reset)
        (state == ST_FETCH && pmem_resp && request) |=> hit);

endmodule

// File: verilog/l2_cache_datapath.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_datapath (
    input  logic                              clk,
    input  logic                              reset,
    input  l2_cache_pkg::l2_word_t            mem_address,
    input  l2_cache_pkg::l2_line_t            mem_wdata,
    input  l2_cache_pkg::l2_line_t            pmem_rdata,
    input  l2_cache_pkg::l2_ctl_t             ctl,
    input  l2_cache_pkg::l2_addr_sel_e        addr_sel,
    input  logic [2:0]                        victim_sel,
    input  logic                              fill,
    output l2_cache_pkg::l2_way_status_arr_t  way_status,
    output l2_cache_pkg::l2_line_t            mem_rdata,
    output l2_cache_pkg::l2_word_t            pmem_address,
    output l2_cache_pkg::l2_line_t            pmem_wdata
);
    import l2_cache_pkg::*;

    l2_addr_t                req_addr;
    l2_line_t                way_wdata;
    l2_line_t                way_rdata [`L2_WAYS];
    logic [`L2_TAG_BITS-1:0] way_tag [`L2_WAYS];

    assign req_addr  = mem_address;
    assign way_wdata = fill ? pmem_rdata : mem_wdata;   // Refill or write hit

    for (genvar i = 0; i < `L2_WAYS; i++) begin : g_way
        l2_cache_way way0 (
            .clk    (clk),
            .reset  (reset),
            .addr   (req_addr),
            .wdata  (way_wdata),
            .ctl    (ctl.way[i]),
            .status (way_status[i]),
            .tag    (way_tag[i]),
            .rdata  (way_rdata[i])
        );
    end

    always_comb begin
        mem_rdata = '0;
        for (int i = 0; i < `L2_WAYS; i++) begin
            if (way_status[i].hit)
                mem_rdata = way_rdata[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered address and line toward memory or victim cache
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (addr_sel == SEL_VICTIM) begin
            pmem_address <= {way_tag[victim_sel], req_addr.set, {`L2_OFFSET_BITS{1'b0}}};
            pmem_wdata   <= way_rdata[victim_sel];
        end else begin
            pmem_address <= {req_addr.tag, req_addr.set, {`L2_OFFSET_BITS{1'b0}}};
            pmem_wdata   <= mem_wdata;
        end
    end

endmodule

// File: verilog/l2_cache.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  l2_cache_pkg::l2_word_t  mem_address,
    input  l2_cache_pkg::l2_line_t  mem_wdata,
    output l2_cache_pkg::l2_line_t  mem_rdata,
    output logic                    mem_resp,
    output logic                    pmem_read,
    output logic                    pmem_write,
    output l2_cache_pkg::l2_word_t  pmem_address,
    output l2_cache_pkg::l2_line_t  pmem_wdata,
    input  l2_cache_pkg::l2_line_t  pmem_rdata,
    input  logic                    pmem_resp,
    output logic                    eviction,
    output logic                    l2hits_inc,
    output logic                    l2misses_inc
);
    import l2_cache_pkg::*;

    l2_way_status_arr_t way_status;
    l2_ctl_t            ctl;
    l2_addr_sel_e       addr_sel;
    logic [2:0]         victim_way;
    logic [2:0]         victim_sel;

    l2_cache_control control0 (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .way_status   (way_status),
        .victim_way   (victim_way),
        .pmem_resp    (pmem_resp),
        .ctl          (ctl),
        .addr_sel     (addr_sel),
        .victim_sel   (victim_sel),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .eviction     (eviction),
        .l2hits_inc   (l2hits_inc),
        .l2misses_inc (l2misses_inc)
    );

    l2_plru plru0 (
        .clk        (clk),
        .reset      (reset),
        .set        (mem_address[`L2_OFFSET_BITS +: `L2_SET_BITS]),
        .load_lru   (ctl.load_lru),
        .hit_way    (victim_sel),
        .victim_way (victim_way)
    );

    // pmem_read is high only while fetching, so it selects refill data
    l2_cache_datapath datapath0 (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .ctl          (ctl),
        .addr_sel     (addr_sel),
        .victim_sel   (victim_sel),
        .fill         (pmem_read),
        .way_status   (way_status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

// File: tb/l2_pmem_model.sv
`timescale 1ns/1ns

module l2_pmem_model (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pmem_read,
    input  logic                    pmem_write,
    input  l2_cache_pkg::l2_word_t  pmem_address,
    input  l2_cache_pkg::l2_line_t  pmem_wdata,
    input  logic                    eviction,
    output l2_cache_pkg::l2_line_t  pmem_rdata,
    output logic                    pmem_resp
);
    import l2_cache_pkg::*;

    l2_line_t   store [l2_word_t];
    l2_word_t   wr_addr_q [$];
    l2_line_t   wr_line_q [$];
    l2_word_t   ev_addr_q [$];
    l2_line_t   ev_line_q [$];
    logic [1:0] wait_cnt;

    // Unwritten lines read back as their own address
    function automatic l2_line_t read_line(input l2_word_t addr);
        if (store.exists(addr))
            return store[addr];
        return {8{addr}};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            wait_cnt   <= '0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;   // Answer lasts one cycle
            wait_cnt  <= '0;
        end else if (pmem_read || pmem_write) begin
            if (wait_cnt == 2'd2) begin
                pmem_resp <= 1'b1;
                if (pmem_read) begin
                    pmem_rdata <= read_line(pmem_address);
                end else begin
                    store[pmem_address] = pmem_wdata;
                    wr_addr_q.push_back(pmem_address);
                    wr_line_q.push_back(pmem_wdata);
                end
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

    // Victim cache side, logged only
    always @(posedge clk) begin
        if (!reset && eviction) begin
            ev_addr_q.push_back(pmem_address);
            ev_line_q.push_back(pmem_wdata);
        end
    end

endmodule

// File: tb/l2_cache_tb.sv
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_tb;
    import l2_cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    typedef struct packed {
        logic     hit;
        logic     victim_valid;
        logic     victim_dirty;
        l2_word_t victim_addr;
        l2_line_t victim_line;
        l2_line_t line;
    } ref_result_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     mem_read;
    logic     mem_write;
    l2_word_t mem_address;
    l2_line_t mem_wdata;
    l2_line_t mem_rdata;
    logic     mem_resp;
    logic     pmem_read;
    logic     pmem_write;
    l2_word_t pmem_address;
    l2_line_t pmem_wdata;
    l2_line_t pmem_rdata;
    logic     pmem_resp;
    logic     eviction;
    logic     l2hits_inc;
    logic     l2misses_inc;

    // Reference cache indexed [set][way]
    logic [`L2_TAG_BITS-1:0] ref_tag   [`L2_SETS][`L2_WAYS];
    logic                    ref_valid [`L2_SETS][`L2_WAYS];
    logic                    ref_dirty [`L2_SETS][`L2_WAYS];
    l2_line_t                ref_data  [`L2_SETS][`L2_WAYS];
    logic [6:0]              ref_plru  [`L2_SETS];
    l2_line_t                ref_mem   [l2_word_t];

    logic [31:0] lcg_state = 32'h5c0a;
    int          errors = 0;
    int          checks = 0;
    int          test_count = 0;
    int          test_start = 0;
    int          miss_total = 0;
    int          ref_misses = 0;

    always #5 clk = ~clk;

    l2_cache dut0 (
        .clk(clk), .reset(reset),
        .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_resp(mem_resp),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp),
        .eviction(eviction), .l2hits_inc(l2hits_inc), .l2misses_inc(l2misses_inc)
    );

    l2_pmem_model mem0 (
        .clk(clk), .reset(reset), .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_address(pmem_address), .pmem_wdata(pmem_wdata), .eviction(eviction),
        .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic l2_word_t make_addr(input logic [`L2_TAG_BITS-1:0] tag,
                                           input logic [`L2_SET_BITS-1:0] set,
                                           input logic [`L2_OFFSET_BITS-1:0] offset);
        l2_addr_t a;
        a.tag    = tag;
        a.set    = set;
        a.offset = offset;
        return a;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference tree PLRU and cache model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [2:0] plru_victim(input logic [6:0] bits);
        int pair;
        if (bits[0])
            pair = bits[2] ? 3 : 2;
        else
            pair = bits[1] ? 1 : 0;
        return 3'(2 * pair + (bits[3 + pair] ? 1 : 0));
    endfunction

    function automatic logic [6:0] plru_touch(input logic [6:0] bits, input logic [2:0] way);
        int w;
        w = int'(way);
        bits[0] = (w < 4);   // Point at the other half
        if (w < 4)
            bits[1] = (w < 2);
        else
            bits[2] = (w < 6);
        bits[3 + w / 2] = (w % 2 == 0);
        return bits;
    endfunction

    function automatic ref_result_t ref_access(input logic write, input l2_word_t addr,
                                               input l2_line_t wdata);
        ref_result_t r;
        l2_addr_t    a;
        l2_word_t    line_addr;
        int          s;
        int          w;
        a = addr;
        s = int'(a.set);
        line_addr = make_addr(a.tag, a.set, '0);
        r = '0;
        w = -1;
        for (int i = 0; i < `L2_WAYS; i++) begin
            if (ref_valid[s][i] && ref_tag[s][i] == a.tag)
                w = i;
        end
        if (w >= 0) begin
            r.hit = 1'b1;
        end else begin
            ref_misses++;
            w = int'(plru_victim(ref_plru[s]));
            r.victim_valid = ref_valid[s][w];
            r.victim_dirty = ref_dirty[s][w];
            r.victim_addr  = make_addr(ref_tag[s][w], a.set, '0);
            r.victim_line  = ref_data[s][w];
            if (r.victim_dirty)
                ref_mem[r.victim_addr] = r.victim_line;
            ref_data[s][w]  = ref_mem.exists(line_addr) ? ref_mem[line_addr] : {8{line_addr}};
            ref_tag[s][w]   = a.tag;
            ref_valid[s][w] = 1'b1;
            ref_dirty[s][w] = 1'b0;
        end
        if (write) begin
            ref_data[s][w]  = wdata;
            ref_dirty[s][w] = 1'b1;
        end
        r.line = ref_data[s][w];
        ref_plru[s] = plru_touch(ref_plru[s], 3'(w));
        return r;
    endfunction

    task automatic clear_ref();
        for (int s = 0; s < `L2_SETS; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_data[s][w]  = '0;
            end
        end
    endtask

    task automatic check_line(input string name, input l2_line_t got, input l2_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input l2_word_t got, input l2_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR: %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One arbiter request held until mem_resp
    //////////////////////////////////////////////////////////////////////
    task automatic access(input logic write, input l2_word_t addr, input l2_line_t wdata);
        ref_result_t exp;
        logic        exp_evict;
        logic        exp_wb;
        logic        done;
        l2_line_t    got;
        int          cyc;
        int          hits;
        int          misses;
        int          evicts;
        int          reads;
        int          wr_before;
        int          ev_before;
        wr_before = mem0.wr_addr_q.size();
        ev_before = mem0.ev_addr_q.size();
        exp       = ref_access(write, addr, wdata);
        exp_evict = !exp.hit && exp.victim_valid && !exp.victim_dirty;
        exp_wb    = !exp.hit && exp.victim_dirty;
        hits   = 0;
        misses = 0;
        evicts = 0;
        reads  = 0;
        cyc    = 0;
        done = 1'b0;
        got  = '0;
        @(posedge clk);
        mem_read    <= !write;
        mem_write   <= write;
        mem_address <= addr;
        mem_wdata   <= wdata;
        while (!done && cyc < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cyc++;
            hits   += int'(l2hits_inc);
            misses += int'(l2misses_inc);
            evicts += int'(eviction);
            reads  += int'(pmem_read);
            if (mem_resp) begin
                done = 1'b1;
                got  = mem_rdata;
            end
        end
        if (!done) begin
            errors++;
            $display("Timeout: no mem_resp within %0d cycles for address %h", cyc, addr);
        end else begin
            miss_total += misses;
            check_count("l2misses_inc pulses", misses, exp.hit ? 0 : 1);
            check_count("l2hits_inc pulses", hits, 1);
            if (!write)
                check_line("mem_rdata", got, exp.line);
            if (exp.hit)
                check_count("pmem_read cycles", reads, 0);
            check_bit("eviction", evicts != 0, exp_evict);
            if (exp_evict && mem0.ev_addr_q.size() > ev_before) begin
                check_count("eviction cycles", evicts, 1);
                check_addr("eviction pmem_address", mem0.ev_addr_q[ev_before], exp.victim_addr);
                check_line("eviction pmem_wdata", mem0.ev_line_q[ev_before], exp.victim_line);
            end
            check_bit("pmem_write", mem0.wr_addr_q.size() > wr_before, exp_wb);
            if (exp_wb && mem0.wr_addr_q.size() > wr_before) begin
                check_addr("write-back pmem_address", mem0.wr_addr_q[wr_before], exp.victim_addr);
                check_line("write-back pmem_wdata", mem0.wr_line_q[wr_before], exp.victim_line);
            end
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, errors - test_start);
        test_start = errors;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        l2_word_t    addr;
        l2_line_t    data;
        reset       = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        clear_ref();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        access(1'b0, make_addr(9'h001, 3'd2, 4'h0), '0);
        end_test("read miss on empty set");
        access(1'b0, make_addr(9'h001, 3'd2, 4'h6), '0);
        end_test("repeated read hits");

        // Fill set 3, touch a few ways, then replace
        for (int i = 0; i < 8; i++)
            access(1'b0, make_addr(9'h010 + 9'(i), 3'd3, 4'h0), '0);
        access(1'b0, make_addr(9'h010, 3'd3, 4'h0), '0);
        access(1'b0, make_addr(9'h013, 3'd3, 4'h0), '0);
        access(1'b0, make_addr(9'h016, 3'd3, 4'h0), '0);
        access(1'b0, make_addr(9'h018, 3'd3, 4'h0), '0);
        end_test("PLRU fill order and replacement");
        access(1'b0, make_addr(9'h019, 3'd3, 4'h0), '0);
        access(1'b0, make_addr(9'h01a, 3'd3, 4'h0), '0);
        end_test("clean victim eviction strobe");

        data = 128'hdead_beef_0123_4567_89ab_cdef_5a5a_a5a5;
        access(1'b1, make_addr(9'h020, 3'd5, 4'h8), data);
        for (int i = 1; i < 9; i++)
            access(1'b0, make_addr(9'h020 + 9'(i), 3'd5, 4'h0), '0);
        access(1'b0, make_addr(9'h020, 3'd5, 4'h0), '0);
        end_test("dirty write-back and reload");

        // Two sets and twelve tags so sets overflow often
        for (int n = 0; n < 200; n++) begin
            r    = lcg_next();
            addr = make_addr(9'(r[27:16] % 12) + 9'h040, {2'b11, r[8]}, r[3:0]);
            data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            access(r[12], addr, data);
        end
        check_count("total misses", miss_total, ref_misses);
        end_test("random reads and writes");

        $display("%0d tests, %0d checks, %0d errors, %0d misses",
                 test_count, checks, errors, miss_total);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/l2_cache_pkg.sv
verilog/l2_cache_way.sv
verilog/l2_plru.sv
verilog/l2_cache_control.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache.sv
tb/l2_pmem_model.sv
tb/l2_cache_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -f all.f --top-module l2_cache_tb -o l2_cache_sim &&
./obj_dir/l2_cache_sim | tee sim.log &&
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: see sim.log"; exit 1; }
echo "PASS"
